// ==== hdl/pipe_defs.svh ====
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// Instruction, immediate, operand and address width.
`define DATA_WIDTH 16

// Eight architectural registers.
`define REG_IDX_WIDTH 3

// Tracked stages after IF: ID, EX, MEM, WB.
`define PIPE_DEPTH 4

// Queue depth and the fetch source's starting credits.
`define QUEUE_CREDITS 4

`endif

// ==== hdl/isaPkg.sv ====
`include "pipe_defs.svh"

package isaPkg;

    typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;

    typedef logic [4:0] opcodeT;

    // Instruction word, most significant field first.
    typedef struct packed {
        opcodeT     opcode;   // Bits 15 to 11.
        regIdxT     rs;       // Bits 10 to 8.
        regIdxT     rt;       // Bits 7 to 5.
        regIdxT     rd;       // Bits 4 to 2.
        logic [1:0] funct;    // Not looked at by issue.
    } instrT;

    // Coarse class, enough for hazard checks.
    // 111xx jump, 011xx branch, 10000 load, 10001 store, rest ALU.
    typedef enum logic [2:0] {
        ALU,
        LOAD,
        STORE,
        BRANCH,
        JUMP
    } opClassT;

endpackage

// ==== hdl/pipePkg.sv ====
`include "pipe_defs.svh"

package pipePkg;

    // Register write in flight. All zero is an empty slot.
    typedef struct packed {
        logic           valid;
        isaPkg::regIdxT rd;
    } regTrackT;

    // Memory access in flight, keyed by effective address.
    typedef struct packed {
        logic                   valid;
        logic [`DATA_WIDTH-1:0] addr;
    } memTrackT;

endpackage

// ==== hdl/instrQueue.sv ====
`timescale 1ns/1ps
`include "pipe_defs.svh"

module instrQueue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inValid,
    input  isaPkg::instrT          inInstr,
    input  logic [`DATA_WIDTH-1:0] inImm,
    input  logic [`DATA_WIDTH-1:0] inReg1Data,
    input  logic                   pop,
    output logic                   headValid,
    output isaPkg::instrT          headInstr,
    output logic [`DATA_WIDTH-1:0] headImm,
    output logic [`DATA_WIDTH-1:0] headReg1Data,
    output logic                   creditReturn
);

    localparam int bundleWidth = 3 * `DATA_WIDTH;
    localparam int ptrWidth    = $clog2(`QUEUE_CREDITS);
    localparam int cntWidth    = $clog2(`QUEUE_CREDITS + 1);

    logic [bundleWidth-1:0] entries [`QUEUE_CREDITS];
    logic [bundleWidth-1:0] headBundle;
    logic [ptrWidth-1:0]    wrPtr;
    logic [ptrWidth-1:0]    rdPtr;
    logic [cntWidth-1:0]    count;
    logic                   doPop;

    // Wraps for any depth, not only powers of two.
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(`QUEUE_CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign headValid = (count != '0);
    assign doPop     = pop & headValid;   // A pop on empty is dropped.

    // Credits guarantee a free slot for every beat.
    always_ff @(posedge clk) begin
        if (inValid) begin
            entries[wrPtr] <= {inInstr, inImm, inReg1Data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end else begin
            creditReturn <= doPop;   // One credit back per pop, a cycle later.
            if (inValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({inValid, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is read from the array, so a new beat shows up a cycle after its write.
    assign headBundle   = entries[rdPtr];
    assign headInstr    = headBundle[bundleWidth-1 -: `DATA_WIDTH];
    assign headImm      = headBundle[2*`DATA_WIDTH-1 -: `DATA_WIDTH];
    assign headReg1Data = headBundle[`DATA_WIDTH-1:0];

endmodule

// ==== hdl/instrDecode.sv ====
`timescale 1ns/1ps
`include "pipe_defs.svh"

module instrDecode (
    input  isaPkg::instrT          headInstr,
    input  logic [`DATA_WIDTH-1:0] headImm,
    input  logic [`DATA_WIDTH-1:0] headReg1Data,
    output isaPkg::regIdxT         rs,
    output isaPkg::regIdxT         rt,
    output isaPkg::regIdxT         rd,
    output isaPkg::opClassT        opClass,
    output logic                   writesReg,
    output logic                   memAccess,
    output logic [`DATA_WIDTH-1:0] memAddr
);

    import isaPkg::*;

    assign rs = headInstr.rs;
    assign rt = headInstr.rt;
    assign rd = headInstr.rd;

    always_comb begin
        casez (headInstr.opcode)
            5'b111??: opClass = JUMP;
            5'b011??: opClass = BRANCH;
            5'b10000: opClass = LOAD;
            5'b10001: opClass = STORE;
            default:  opClass = ALU;
        endcase
    end

    // Loads and ALU ops produce a result in rd.
    assign writesReg = (opClass == ALU) || (opClass == LOAD);
    assign memAccess = (opClass == LOAD) || (opClass == STORE);

    // Base plus immediate. Carry out dropped.
    assign memAddr = headReg1Data + headImm;

endmodule

// ==== hdl/stageTrack.sv ====
`timescale 1ns/1ps
`include "pipe_defs.svh"

module stageTrack #(
    parameter type recordT = logic
) (
    input  logic   clk,
    input  logic   rst,
    input  recordT recIn,
    output recordT stageRec [`PIPE_DEPTH]
);

    // Slot 0 is ID, the last slot is WB.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_DEPTH; i++) begin
                stageRec[i] <= '0;   // Zero means empty.
            end
        end else begin
            stageRec[0] <= recIn;
            for (int i = 1; i < `PIPE_DEPTH; i++) begin
                stageRec[i] <= stageRec[i-1];   // No stall downstream.
            end
        end
    end

endmodule

// ==== hdl/hazardCtrl.sv ====
`timescale 1ns/1ps
`include "pipe_defs.svh"

module hazardCtrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   headValid,
    input  isaPkg::regIdxT         rs,
    input  isaPkg::regIdxT         rt,
    input  isaPkg::regIdxT         rd,
    input  isaPkg::opClassT        opClass,
    input  logic                   writesReg,
    input  logic                   memAccess,
    input  logic [`DATA_WIDTH-1:0] memAddr,
    input  pipePkg::regTrackT      regStages [`PIPE_DEPTH],
    input  pipePkg::memTrackT      memStages [`PIPE_DEPTH],
    output logic                   pop,
    output logic                   issueValid,
    output logic                   nop,
    output logic                   pcStall,
    output pipePkg::regTrackT      regIn,
    output pipePkg::memTrackT      memIn
);

    import isaPkg::*;

    logic regHaz;
    logic memHaz;
    logic hazard;
    logic issue;
    logic shadow;
    logic isJumpBranch;

    // Both source fields checked, whether the op reads rt or not.
    always_comb begin
        regHaz = 1'b0;
        memHaz = 1'b0;
        for (int i = 0; i < `PIPE_DEPTH; i++) begin
            if (regStages[i].valid &&
                (regStages[i].rd == rs || regStages[i].rd == rt)) begin
                regHaz = 1'b1;
            end
            // Only memory ops leave valid memory records.
            if (memAccess && memStages[i].valid && memStages[i].addr == memAddr) begin
                memHaz = 1'b1;
            end
        end
    end

    assign hazard       = headValid & (regHaz | memHaz);
    assign isJumpBranch = (opClass == BRANCH) || (opClass == JUMP);

    assign issue      = headValid & ~hazard & ~shadow;
    assign pop        = issue;
    assign issueValid = issue;
    assign nop        = ~issue;              // Any cycle without an issue is a bubble.
    assign pcStall    = hazard & ~shadow;    // The shadow bubble does not hold fetch.

    // One slot after a control transfer.
    always_ff @(posedge clk) begin
        if (rst) begin
            shadow <= 1'b0;
        end else begin
            shadow <= issue & isJumpBranch;
        end
    end

    always_comb begin
        regIn = '0;
        memIn = '0;
        if (issue) begin
            regIn.valid = writesReg;
            regIn.rd    = rd;
            memIn.valid = memAccess;
            memIn.addr  = memAddr;
        end
    end

endmodule

// ==== hdl/issueStage.sv ====
`timescale 1ns/1ps
`include "pipe_defs.svh"

module issueStage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inValid,
    input  isaPkg::instrT          inInstr,
    input  logic [`DATA_WIDTH-1:0] inImm,
    input  logic [`DATA_WIDTH-1:0] inReg1Data,
    output logic                   creditReturn,
    output logic                   issueValid,
    output isaPkg::instrT          issueInstr,
    output logic [`DATA_WIDTH-1:0] issueAddr,
    output logic                   nop,
    output logic                   pcStall
);

    import isaPkg::*;
    import pipePkg::*;

    logic                   headValid;
    instrT                  headInstr;
    logic [`DATA_WIDTH-1:0] headImm;
    logic [`DATA_WIDTH-1:0] headReg1Data;
    logic                   pop;
    regIdxT                 rs;
    regIdxT                 rt;
    regIdxT                 rd;
    opClassT                opClass;
    logic                   writesReg;
    logic                   memAccess;
    logic [`DATA_WIDTH-1:0] memAddr;
    regTrackT               regIn;
    memTrackT               memIn;
    regTrackT               regStages [`PIPE_DEPTH];
    memTrackT               memStages [`PIPE_DEPTH];

    instrQueue uQueue (
        .clk, .rst, .inValid, .inInstr, .inImm, .inReg1Data, .pop,
        .headValid, .headInstr, .headImm, .headReg1Data, .creditReturn
    );

    instrDecode uDecode (
        .headInstr, .headImm, .headReg1Data,
        .rs, .rt, .rd, .opClass, .writesReg, .memAccess, .memAddr
    );

    stageTrack #(.recordT(regTrackT)) uRegTrack (.clk, .rst, .recIn(regIn), .stageRec(regStages));

    stageTrack #(.recordT(memTrackT)) uMemTrack (.clk, .rst, .recIn(memIn), .stageRec(memStages));

    hazardCtrl uCtrl (
        .clk, .rst, .headValid, .rs, .rt, .rd, .opClass, .writesReg, .memAccess,
        .memAddr, .regStages, .memStages,
        .pop, .issueValid, .nop, .pcStall, .regIn, .memIn
    );

    // Meaningful only with issueValid.
    assign issueInstr = headInstr;
    assign issueAddr  = memAddr;

endmodule

// ==== verification/clkGen.sv ====
`timescale 1ns/1ps

module clkGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;   // Released on the third rising edge.
    end

    always #20 clk = ~clk;   // 40 ns period.

endmodule

// ==== verification/issueChecker.sv ====
`timescale 1ns/1ps
`include "pipe_defs.svh"

module issueChecker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inValid,
    input  isaPkg::instrT          inInstr,
    input  logic [`DATA_WIDTH-1:0] inImm,
    input  logic [`DATA_WIDTH-1:0] inReg1Data,
    input  logic                   creditReturn,
    input  logic                   issueValid,
    input  isaPkg::instrT          issueInstr,
    input  logic [`DATA_WIDTH-1:0] issueAddr,
    input  logic                   nop,
    input  logic                   pcStall,
    output int                     errorCount,
    output int                     issuedCount
);

    import isaPkg::*;
    import pipePkg::*;

    logic [3*`DATA_WIDTH-1:0] pending [$];   // Sent and not yet issued.
    regTrackT                 regModel [`PIPE_DEPTH];
    memTrackT                 memModel [`PIPE_DEPTH];
    logic                     shadowModel;
    logic                     issuedLast;
    int                       credits;

    task automatic compareValue(input string what, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin
        instrT       head;
        logic [15:0] headAddr;
        logic        hazard;
        logic        expIssue;
        if (rst) begin
            pending.delete();
            for (int i = 0; i < `PIPE_DEPTH; i++) begin
                regModel[i] = '0;
                memModel[i] = '0;
            end
            shadowModel = 1'b0;
            issuedLast  = 1'b0;
            credits     = `QUEUE_CREDITS;
            errorCount  = 0;
            issuedCount = 0;
        end else begin
            head     = '0;
            headAddr = '0;
            if (pending.size() != 0) begin
                head     = pending[0][47:32];
                headAddr = pending[0][31:16] + pending[0][15:0];   // Wraps at 16 bits.
            end
            hazard = 1'b0;
            for (int i = 0; i < `PIPE_DEPTH; i++) begin
                hazard |= (pending.size() != 0) && regModel[i].valid &&
                    (regModel[i].rd == head.rs || regModel[i].rd == head.rt);
                hazard |= (pending.size() != 0) && memModel[i].valid &&
                    memModel[i].addr == headAddr && head.opcode[4:1] == 4'b1000;
            end
            expIssue = (pending.size() != 0) && !hazard && !shadowModel;
            compareValue("issueValid", issueValid, expIssue);
            compareValue("pcStall", pcStall, hazard && !shadowModel);
            compareValue("nop", nop, !expIssue);
            compareValue("creditReturn", creditReturn, issuedLast);
            if (expIssue && issueValid) begin
                compareValue("issueInstr", issueInstr, head);
                compareValue("issueAddr", issueAddr, headAddr);
            end
            if (inValid && credits == 0) begin
                errorCount++;
                $display("ERROR at %0t: bundle sent with no credit left", $time);
            end
            credits = credits - inValid + creditReturn;
            if (credits > `QUEUE_CREDITS) begin
                errorCount++;
                $display("ERROR at %0t: source holds %0d credits", $time, credits);
            end
            // Records move one stage per cycle, WB drops off.
            for (int i = `PIPE_DEPTH - 1; i > 0; i--) begin
                regModel[i] = regModel[i-1];
                memModel[i] = memModel[i-1];
            end
            regModel[0] = '0;
            memModel[0] = '0;
            if (expIssue) begin
                regModel[0].valid = (head.opcode[3:2] != 2'b11) && (head.opcode != 5'b10001);
                regModel[0].rd    = head.rd;
                memModel[0].valid = (head.opcode[4:1] == 4'b1000);
                memModel[0].addr  = headAddr;
                void'(pending.pop_front());
            end
            shadowModel = expIssue && (head.opcode[3:2] == 2'b11);   // Branch or jump.
            issuedLast  = expIssue;
            if (issueValid) begin
                issuedCount++;
            end
            if (inValid) begin
                pending.push_back({inInstr, inImm, inReg1Data});
            end
        end
    end

endmodule

// ==== verification/issueTb.sv ====
`timescale 1ns/1ps
`include "pipe_defs.svh"

module issueTb;

    import isaPkg::*;

    localparam int totalBundles = 600;
    localparam int cycleLimit   = totalBundles * 6 + 200;

    logic                   clk;
    logic                   rst;
    logic                   inValid;
    instrT                  inInstr;
    logic [`DATA_WIDTH-1:0] inImm;
    logic [`DATA_WIDTH-1:0] inReg1Data;
    logic                   creditReturn;
    logic                   issueValid;
    instrT                  issueInstr;
    logic [`DATA_WIDTH-1:0] issueAddr;
    logic                   nop;
    logic                   pcStall;
    int                     errorCount;
    int                     issuedCount;
    int                     cycleCount = 0;
    logic                   finished = 1'b0;

    clkGen uClk (.clk, .rst);

    issueStage DUT (
        .clk, .rst, .inValid, .inInstr, .inImm, .inReg1Data,
        .creditReturn, .issueValid, .issueInstr, .issueAddr, .nop, .pcStall
    );

    issueChecker uChecker (
        .clk, .rst, .inValid, .inInstr, .inImm, .inReg1Data, .creditReturn,
        .issueValid, .issueInstr, .issueAddr, .nop, .pcStall, .errorCount, .issuedCount
    );

    // One eighth jumps or branches, one quarter loads or stores.
    function automatic opcodeT makeOpcode();
        logic [31:0] bits;
        bits = $urandom;
        case (bits[2:0])
            3'd0:       return {bits[3] ? 3'b111 : 3'b011, bits[5:4]};
            3'd1, 3'd2: return {4'b1000, bits[3]};
            default:    return bits[3] ? {2'b00, bits[6:4]} : {3'b110, bits[5:4]};
        endcase
    endfunction

    initial begin
        int          credits;
        int          sentCount;
        logic        sendNow;
        logic [31:0] bits;
        void'($urandom(31374));
        inValid    = 1'b0;
        inInstr    = '0;
        inImm      = '0;
        inReg1Data = '0;
        credits    = `QUEUE_CREDITS;
        sentCount  = 0;
        do @(posedge clk); while (rst);
        while (sentCount < totalBundles) begin
            bits    = $urandom;
            sendNow = (credits > 0) && (bits[31:30] != 2'b00);   // Random rate.
            credits = credits - sendNow + creditReturn;
            inValid <= sendNow;
            if (sendNow) begin
                // Registers 0 to 3 only, so sources often match a writer.
                inInstr    <= {makeOpcode(), 1'b0, bits[1:0], 1'b0, bits[3:2],
                               1'b0, bits[5:4], bits[7:6]};
                inImm      <= bits[8] ? 16'hFFF8 : {13'd0, bits[9], 2'b00};
                inReg1Data <= 16'h0100 + {bits[11:10], 2'b00};   // Few bases so addresses repeat.
                sentCount++;
            end
            @(posedge clk);
        end
        inValid <= 1'b0;
    end

    initial begin
        wait (issuedCount == totalBundles);
        repeat (3) @(posedge clk);   // Lets the last shadow and credit checks run.
        finished = 1'b1;
        $display("Errors: %0d, bundles issued: %0d of %0d", errorCount, issuedCount,
                 totalBundles);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (!finished && cycleCount >= cycleLimit) begin
            $display("Timeout: only %0d of %0d bundles issued after %0d cycles, errors: %0d",
                     issuedCount, totalBundles, cycleCount, errorCount);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/instrQueue.sv
hdl/instrDecode.sv
hdl/stageTrack.sv
hdl/hazardCtrl.sv
hdl/issueStage.sv
verification/clkGen.sv
verification/issueChecker.sv
verification/issueTb.sv
